// File: fpu_types_pkg.sv
// binary32 operand layout, operation and rounding codes, exception flags
// imported by the three pipeline stages, the top level and the testbench
`default_nettype none

package fpu_types_pkg;

   typedef struct packed {
      logic        sign;
      logic [7:0]  exp;   // biased by 127
      logic [22:0] frac;
   } fp32_t;

   // funct7 encodings of the core's fp instructions
   typedef enum logic [6:0] {
      FPU_ADD = 7'b0100000,
      FPU_SUB = 7'b0100100,
      FPU_MUL = 7'b0000010
   } fpu_op_e;

   typedef enum logic [2:0] {
      RM_RNE = 3'b000,   // nearest even
      RM_RTZ = 3'b001,
      RM_RDN = 3'b010,   // toward minus infinity
      RM_RUP = 3'b011,   // toward plus infinity
      RM_RMM = 3'b100    // nearest with ties away from zero
   } round_mode_e;

   // bit order matches the fflags csr
   typedef struct packed {
      logic nv;   // invalid operation
      logic dz;   // no divider so always clear
      logic of;
      logic uf;
      logic nx;
   } fpu_flags_t;

   // subnormals are treated as zero
   typedef enum logic [1:0] {CLS_ZERO, CLS_NORMAL, CLS_INF, CLS_NAN} fp_class_t;

   localparam fp32_t FP32_QNAN = 32'h7fc00000;   // canonical quiet nan

endpackage

`default_nettype wire

// File: fpu_pipe_pkg.sv
// layouts of the two registers between the fpu pipeline stages
// align_stage_t feeds stage 2 and combine_stage_t feeds stage 3
`default_nettype none

package fpu_pipe_pkg;
   import fpu_types_pkg::*;

   typedef struct packed {
      logic              valid;
      fpu_op_e           op;
      round_mode_e       rm;
      logic              special;      // special_val replaces the datapath result
      fp32_t             special_val;
      logic              nv;
      logic              sign;         // larger operand sign or product sign
      logic              eff_sub;      // add of opposite signs
      logic [26:0]       sig_big;      // product[47:21] for mul
      logic [26:0]       sig_small;    // product[20:0] in the low bits for mul
      logic signed [9:0] exp;          // exponent sum without bias removed for mul
   } align_stage_t;

   // magnitude keeps a carry bit on top and sticky in bit 0
   typedef struct packed {
      logic              valid;
      fpu_op_e           op;
      round_mode_e       rm;
      logic              special;
      fp32_t             special_val;
      logic              nv;
      logic              sign;
      logic [27:0]       mag;
      logic signed [9:0] exp;
      logic              zero;         // exact zero
   } combine_stage_t;

endpackage

`default_nettype wire

// File: fpu_align.sv
// fpu stage 1 samples the operands on start and classifies them
// resolves nan/inf cases, orders and aligns addends or forms the 24x24 product
`timescale 1ns/100ps
`default_nettype none

module fpu_align
   import fpu_types_pkg::*, fpu_pipe_pkg::*;
(
   input  wire              clk,
   input  wire              nrst,
   input  wire              start,
   input  wire fpu_op_e     op,
   input  wire round_mode_e frm,
   input  wire fp32_t       a,
   input  wire fp32_t       b,
   output align_stage_t     stage
);

   logic         start_q;    // operands captured at the start edge
   fpu_op_e      op_q;
   round_mode_e  frm_q;
   fp32_t        a_q;
   fp32_t        b_q;
   fp32_t        b_eff;      // b with sign flipped for sub
   fp32_t        op_big;
   fp32_t        op_small;
   fp_class_t    cls_a;
   fp_class_t    cls_b;
   logic         is_mul;
   logic         eff_sub;
   logic [7:0]   exp_diff;
   logic [4:0]   shamt;
   logic [49:0]  shifted;
   logic [47:0]  product;
   align_stage_t nxt;

   function automatic fp_class_t classify(input fp32_t x);
      if (x.exp == 8'hff)
         return (x.frac == '0) ? CLS_INF : CLS_NAN;
      if (x.exp == 8'h00)
         return CLS_ZERO;   // flush subnormal
      return CLS_NORMAL;
   endfunction

   // significand with hidden bit
   function automatic logic [23:0] sig_of(input fp32_t x);
      return (x.exp != 8'h00) ? {1'b1, x.frac} : 24'd0;
   endfunction

   always_comb begin
      is_mul = (op_q == FPU_MUL);   // unknown codes run as add
      b_eff  = b_q;
      if (op_q == FPU_SUB)
         b_eff.sign = ~b_q.sign;
      cls_a   = classify(a_q);
      cls_b   = classify(b_eff);
      eff_sub = a_q.sign ^ b_eff.sign;

      // exponent and fraction compare as one unsigned magnitude
      if (a_q[30:0] >= b_eff[30:0]) begin
         op_big   = a_q;
         op_small = b_eff;
      end else begin
         op_big   = b_eff;
         op_small = a_q;
      end

      exp_diff = op_big.exp - op_small.exp;
      shamt    = (exp_diff > 8'd26) ? 5'd26 : exp_diff[4:0];   // 26 already clears all
      shifted  = {sig_of(op_small), 26'd0} >> shamt;
      product  = sig_of(a_q) * sig_of(b_q);

      nxt       = '0;
      nxt.valid = start_q;
      nxt.op    = op_q;
      nxt.rm    = frm_q;
      if (is_mul) begin
         nxt.sign      = a_q.sign ^ b_q.sign;
         nxt.sig_big   = product[47:21];
         nxt.sig_small = {6'd0, product[20:0]};
         nxt.exp       = {2'b00, a_q.exp} + {2'b00, b_q.exp};
      end else begin
         nxt.sign      = op_big.sign;
         nxt.eff_sub   = eff_sub;
         nxt.sig_big   = {sig_of(op_big), 3'b000};
         nxt.sig_small = {shifted[49:24], |shifted[23:0]};   // guard, round, sticky
         nxt.exp       = {2'b00, op_big.exp};
      end

      // special values win over the datapath in stage 3
      if (cls_a == CLS_NAN || cls_b == CLS_NAN) begin
         nxt.special     = 1'b1;
         nxt.special_val = FP32_QNAN;
      end else if (is_mul) begin
         if ((cls_a == CLS_INF && cls_b == CLS_ZERO) ||
             (cls_a == CLS_ZERO && cls_b == CLS_INF)) begin
            nxt.special     = 1'b1;
            nxt.special_val = FP32_QNAN;
            nxt.nv          = 1'b1;
         end else if (cls_a == CLS_INF || cls_b == CLS_INF) begin
            nxt.special     = 1'b1;
            nxt.special_val = {a_q.sign ^ b_q.sign, 8'hff, 23'd0};
         end
      end else if (cls_a == CLS_INF && cls_b == CLS_INF && eff_sub) begin
         nxt.special     = 1'b1;   // inf - inf
         nxt.special_val = FP32_QNAN;
         nxt.nv          = 1'b1;
      end else if (cls_a == CLS_INF || cls_b == CLS_INF) begin
         nxt.special     = 1'b1;
         nxt.special_val = {op_big.sign, 8'hff, 23'd0};   // inf sorts as the bigger one
      end
   end

   always_ff @(posedge clk, negedge nrst) begin
      if (!nrst) begin
         start_q <= 1'b0;
         op_q    <= FPU_ADD;
         frm_q   <= RM_RNE;
         a_q     <= '0;
         b_q     <= '0;
         stage   <= '0;
      end else begin
         start_q <= start;
         op_q    <= op;
         frm_q   <= frm;
         a_q     <= a;
         b_q     <= b;
         stage   <= nxt;
      end
   end

   a_known_op: assert property (@(posedge clk) disable iff (!nrst)
      start |-> op inside {FPU_ADD, FPU_SUB, FPU_MUL})
      else $error("fpu_align: unknown op code %b", op);

endmodule

`default_nettype wire

// File: fpu_combine.sv
// fpu stage 2 adds or subtracts the aligned significands
// for mul it compresses the product to 28 bits and removes one bias
`timescale 1ns/100ps
`default_nettype none

module fpu_combine
   import fpu_types_pkg::*, fpu_pipe_pkg::*;
(
   input  wire                clk,
   input  wire                nrst,
   input  wire align_stage_t  stage_in,
   output combine_stage_t     stage_out
);

   logic           is_mul;
   logic [27:0]    mag;
   combine_stage_t nxt;

   always_comb begin
      is_mul = (stage_in.op == FPU_MUL);

      if (is_mul)
         mag = {stage_in.sig_big, |stage_in.sig_small[20:0]};   // low product bits to sticky
      else if (stage_in.eff_sub)
         mag = {1'b0, stage_in.sig_big} - {1'b0, stage_in.sig_small};
      else
         mag = {1'b0, stage_in.sig_big} + {1'b0, stage_in.sig_small};

      nxt             = '0;
      nxt.valid       = stage_in.valid;
      nxt.op          = stage_in.op;
      nxt.rm          = stage_in.rm;
      nxt.special     = stage_in.special;
      nxt.special_val = stage_in.special_val;
      nxt.nv          = stage_in.nv;
      nxt.mag         = mag;
      nxt.exp         = is_mul ? stage_in.exp - 10'sd127 : stage_in.exp;
      nxt.zero        = (mag == '0);
      nxt.sign        = stage_in.sign;

      // x - x is +0 except when rounding down
      if (nxt.zero && stage_in.eff_sub)
         nxt.sign = (stage_in.rm == RM_RDN);
   end

   always_ff @(posedge clk, negedge nrst) begin
      if (!nrst) begin
         stage_out <= '0;
      end else begin
         stage_out <= nxt;
      end
   end

   // stage 1 ordering keeps the difference non-negative
   a_sub_order: assert property (@(posedge clk) disable iff (!nrst)
      stage_in.valid && stage_in.eff_sub && !stage_in.special
         |-> stage_in.sig_big >= stage_in.sig_small)
      else $error("fpu_combine: subtrahend larger than minuend");

endmodule

`default_nettype wire

// File: fpu_round.sv
// fpu stage 3 normalises, rounds by mode and packs the binary32 result
// also applies overflow, flush to zero and special overrides, then raises flags
`timescale 1ns/100ps
`default_nettype none

module fpu_round
   import fpu_types_pkg::*, fpu_pipe_pkg::*;
(
   input  wire                  clk,
   input  wire                  nrst,
   input  wire combine_stage_t  stage_in,
   output fp32_t                result,
   output fpu_flags_t           flags,
   output logic                 done
);

   logic [4:0]        lzc;
   logic [27:0]       norm;         // leading one at bit 27
   logic signed [9:0] exp_n;        // exponent after normalising
   logic signed [9:0] exp_r;        // exponent after rounding carry
   logic              lsb;
   logic              guard;
   logic              sticky;
   logic              inexact;
   logic              round_up;
   logic [24:0]       mant;
   logic              max_finite;   // overflow saturates for this mode and sign
   fp32_t             res_nxt;
   fpu_flags_t        flags_nxt;

   always_comb begin
      // highest set bit wins
      lzc = 5'd0;
      for (int i = 0; i < 28; i++) begin
         if (stage_in.mag[i])
            lzc = 5'(27 - i);
      end
      norm  = stage_in.mag << lzc;
      exp_n = stage_in.exp + 10'sd1 - $signed({5'd0, lzc});

      lsb     = norm[4];
      guard   = norm[3];
      sticky  = |norm[2:0];
      inexact = guard | sticky;

      case (stage_in.rm)
         RM_RTZ:  round_up = 1'b0;
         RM_RDN:  round_up = inexact & stage_in.sign;
         RM_RUP:  round_up = inexact & ~stage_in.sign;
         RM_RMM:  round_up = guard;
         default: round_up = guard & (sticky | lsb);   // reserved codes round like rne
      endcase

      mant  = {1'b0, norm[27:4]} + {24'd0, round_up};
      exp_r = exp_n + $signed({9'd0, mant[24]});   // carry leaves a zero fraction

      max_finite = (stage_in.rm == RM_RTZ) ||
                   (stage_in.rm == RM_RDN && !stage_in.sign) ||
                   (stage_in.rm == RM_RUP && stage_in.sign);

      flags_nxt = '0;
      if (stage_in.special) begin
         res_nxt      = stage_in.special_val;
         flags_nxt.nv = stage_in.nv;
      end else if (stage_in.zero) begin
         res_nxt = {stage_in.sign, 31'd0};
      end else if (exp_n <= 10'sd0) begin
         res_nxt      = {stage_in.sign, 31'd0};   // no subnormals
         flags_nxt.uf = 1'b1;
         flags_nxt.nx = 1'b1;
      end else if (exp_r >= 10'sd255) begin
         if (max_finite)
            res_nxt = {stage_in.sign, 8'hfe, 23'h7fffff};
         else
            res_nxt = {stage_in.sign, 8'hff, 23'd0};
         flags_nxt.of = 1'b1;
         flags_nxt.nx = 1'b1;
      end else begin
         res_nxt      = {stage_in.sign, exp_r[7:0], mant[22:0]};
         flags_nxt.nx = inexact;
      end
   end

   // result and flags hold between operations
   always_ff @(posedge clk, negedge nrst) begin
      if (!nrst) begin
         result <= '0;
         flags  <= '0;
         done   <= 1'b0;
      end else begin
         done <= stage_in.valid;
         if (stage_in.valid) begin
            result <= res_nxt;
            flags  <= flags_nxt;
         end
      end
   end

   a_done_known: assert property (@(posedge clk) disable iff (!nrst)
      !$isunknown(done))
      else $error("fpu_round: done is unknown");

endmodule

`default_nettype wire

// File: fpu_top.sv
// three-stage binary32 add/sub/mul unit
// start with op, frm, a and b gives done with result and flags three edges later
`timescale 1ns/100ps
`default_nettype none

module fpu_top
   import fpu_types_pkg::*, fpu_pipe_pkg::*;
(
   input  wire              clk,
   input  wire              nrst,
   input  wire              start,
   input  wire fpu_op_e     op,
   input  wire round_mode_e frm,
   input  wire fp32_t       a,
   input  wire fp32_t       b,
   output fp32_t            result,
   output fpu_flags_t       flags,
   output logic             done
);

   align_stage_t   s1;   // stage 1 to stage 2
   combine_stage_t s2;   // stage 2 to stage 3

   fpu_align fpu_align_i (
      .clk   (clk),
      .nrst  (nrst),
      .start (start),
      .op    (op),
      .frm   (frm),
      .a     (a),
      .b     (b),
      .stage (s1)
   );

   fpu_combine fpu_combine_i (
      .clk       (clk),
      .nrst      (nrst),
      .stage_in  (s1),
      .stage_out (s2)
   );

   fpu_round fpu_round_i (
      .clk      (clk),
      .nrst     (nrst),
      .stage_in (s2),
      .result   (result),
      .flags    (flags),
      .done     (done)
   );

endmodule

`default_nettype wire

// File: tb_fpu.sv
// testbench for fpu_top that streams the vectors of fpu_testdata.txt back to back
// and checks every result, flag set and the three-edge start to done latency
`timescale 1ns/100ps
`default_nettype none

module tb_fpu
   import fpu_types_pkg::*;
();

   localparam int MAX_VEC      = 64;
   localparam int RESET_CYCLES = 5;
   localparam int LATENCY      = 3;   // edges from start sample to done

   typedef struct packed {
      fp32_t       res;
      fpu_flags_t  flg;
      logic [15:0] idx;
      logic [31:0] due_edge;   // edge count when done must be high
   } expect_t;

   logic        clk;
   logic        nrst;
   logic        start;
   fpu_op_e     op;
   round_mode_e frm;
   fp32_t       a;
   fp32_t       b;
   fp32_t       result;
   fpu_flags_t  flags;
   logic        done;

   fpu_op_e     vec_op  [MAX_VEC];
   round_mode_e vec_rm  [MAX_VEC];
   fp32_t       vec_a   [MAX_VEC];
   fp32_t       vec_b   [MAX_VEC];
   fp32_t       vec_res [MAX_VEC];
   fpu_flags_t  vec_flg [MAX_VEC];
   int          n_vec      = 0;
   logic        loaded     = 1'b0;
   int          edge_count = 0;
   expect_t     exp_q[$];   // one entry per operation in flight

   fpu_top fpu_top_i (
      .clk    (clk),
      .nrst   (nrst),
      .start  (start),
      .op     (op),
      .frm    (frm),
      .a      (a),
      .b      (b),
      .result (result),
      .flags  (flags),
      .done   (done)
   );

   always #4 clk = ~clk;

   always @(posedge clk)
      edge_count <= edge_count + 1;

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "run stopped at %0t ns", $time);
   endtask

   task automatic check_result(input fp32_t got, input fp32_t want, input int idx);
      if (got !== want)
         stop_with_error($sformatf(
            "CHECK FAILED at %0t ns: result got %h expected %h (vector %0d)",
            $time, got, want, idx));
   endtask

   task automatic check_flags(input fpu_flags_t got, input fpu_flags_t want, input int idx);
      if (got !== want)
         stop_with_error($sformatf(
            "CHECK FAILED at %0t ns: flags got %b expected %b (vector %0d)",
            $time, got, want, idx));
   endtask

   task automatic check_done_edge(input int got, input int want, input int idx);
      if (got != want)
         stop_with_error($sformatf(
            "CHECK FAILED at %0t ns: done at edge %0d expected %0d (vector %0d)",
            $time, got, want, idx));
   endtask

   task automatic load_vectors();
      integer           fd;
      integer           cnt;
      logic [8*160-1:0] line;
      logic [31:0]      f_op;
      logic [31:0]      f_rm;
      logic [31:0]      f_a;
      logic [31:0]      f_b;
      logic [31:0]      f_res;
      logic [31:0]      f_flg;
      fd = $fopen("fpu_testdata.txt", "r");
      if (fd == 0)
         stop_with_error("could not open fpu_testdata.txt");
      while ($fgets(line, fd) != 0) begin
         cnt = $sscanf(line, "%h %h %h %h %h %h", f_op, f_rm, f_a, f_b, f_res, f_flg);
         if (cnt == 6) begin   // comment and blank lines match nothing
            if (n_vec == MAX_VEC)
               stop_with_error("fpu_testdata.txt holds more vectors than the testbench stores");
            vec_op[n_vec]  = fpu_op_e'(f_op[6:0]);
            vec_rm[n_vec]  = round_mode_e'(f_rm[2:0]);
            vec_a[n_vec]   = f_a;
            vec_b[n_vec]   = f_b;
            vec_res[n_vec] = f_res;
            vec_flg[n_vec] = f_flg[4:0];
            n_vec++;
         end
      end
      $fclose(fd);
      if (n_vec == 0)
         stop_with_error("fpu_testdata.txt holds no vectors");
   endtask

   // drive one operation just after the edge so the next edge samples it
   task automatic issue_vector(input int i);
      expect_t e;
      @(posedge clk);
      #1;
      start = 1'b1;
      op    = vec_op[i];
      frm   = vec_rm[i];
      a     = vec_a[i];
      b     = vec_b[i];
      e.res      = vec_res[i];
      e.flg      = vec_flg[i];
      e.idx      = 16'(i);
      e.due_edge = 32'(edge_count + 1 + LATENCY);
      exp_q.push_back(e);
   endtask

   // outputs are stable at the falling edge
   always @(negedge clk) begin : watch_outputs
      expect_t e;
      if (!nrst) begin
         if (done !== 1'b0)
            stop_with_error("done was not low while reset was asserted");
      end else if ($isunknown(done)) begin
         stop_with_error("done went unknown after reset");
      end else if (done) begin
         if (exp_q.size() == 0)
            stop_with_error("done was raised with no operation outstanding");
         e = exp_q.pop_front();
         check_done_edge(edge_count, int'(e.due_edge), int'(e.idx));
         check_result(result, e.res, int'(e.idx));
         check_flags(flags, e.flg, int'(e.idx));
      end
   end

   initial begin : watchdog
      wait (loaded);
      repeat (RESET_CYCLES + n_vec + 20) @(posedge clk);
      stop_with_error("watchdog expired before all results were checked");
   end

   initial begin : main
      int waited;
      clk   = 1'b0;
      nrst  = 1'b0;
      start = 1'b0;
      op    = FPU_ADD;
      frm   = RM_RNE;
      a     = '0;
      b     = '0;
      load_vectors();
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      nrst = 1'b1;
      for (int i = 0; i < n_vec; i++)
         issue_vector(i);   // one per cycle back to back
      @(posedge clk);
      #1;
      start = 1'b0;
      waited = 0;
      while (exp_q.size() != 0 && waited < 2 * LATENCY) begin
         @(posedge clk);
         waited++;
      end
      repeat (4) @(posedge clk);   // room for a stray done
      if (exp_q.size() != 0) begin
         stop_with_error($sformatf("%0d expected results never arrived", exp_q.size()));
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: fpu_testdata.txt
# columns, all hex: op rm a b expected_result expected_flags
# op 20 add, 24 sub, 02 mul; rm 0 rne 1 rtz 2 rdn 3 rup 4 rmm; flags nv dz of uf nx
20 0 3f800000 40000000 40400000 00
24 0 40a00000 40400000 40000000 00
20 0 3fc00000 3e800000 3fe00000 00
24 0 3f800000 40800000 c0400000 00
20 0 c0200000 bf000000 c0400000 00
02 0 40400000 c0000000 c0c00000 00
02 0 3fc00000 3fc00000 40100000 00
20 0 00000001 3f800000 3f800000 00
# inexact negative product with a tie, all five modes
02 0 bf800003 3fc00000 bfc00004 01
02 1 bf800003 3fc00000 bfc00004 01
02 2 bf800003 3fc00000 bfc00005 01
02 3 bf800003 3fc00000 bfc00004 01
02 4 bf800003 3fc00000 bfc00005 01
# inexact positive sum with a tie, all five modes
20 0 3f800000 33800000 3f800000 01
20 1 3f800000 33800000 3f800000 01
20 2 3f800000 33800000 3f800000 01
20 3 3f800000 33800000 3f800001 01
20 4 3f800000 33800000 3f800001 01
# cancellation and flush to zero
24 0 40400000 40400000 00000000 00
24 2 40400000 40400000 80000000 00
20 3 c0400000 40400000 00000000 00
24 0 00c00000 00800000 00000000 03
02 0 0d800000 30800000 00000000 03
02 0 8d800000 30800000 80000000 03
# overflow
02 0 7f000000 40000000 7f800000 05
02 1 7f000000 40000000 7f7fffff 05
02 2 7f000000 40000000 7f7fffff 05
02 3 7f000000 40000000 7f800000 05
02 4 7f000000 40000000 7f800000 05
02 2 ff000000 40000000 ff800000 05
02 3 ff000000 40000000 ff7fffff 05
20 0 7f7fffff 7f7fffff 7f800000 05
# special values
24 0 7f800000 7f800000 7fc00000 10
02 0 00000000 7f800000 7fc00000 10
20 0 7fc00000 3f800000 7fc00000 00
02 0 7f800001 40000000 7fc00000 00
20 0 7f800000 c0400000 7f800000 00
24 0 3f800000 7f800000 ff800000 00

// File: src.f
fpu_types_pkg.sv
fpu_pipe_pkg.sv
fpu_align.sv
fpu_combine.sv
fpu_round.sv
fpu_top.sv
tb_fpu.sv
